/* Makefile */
# Verilator simulation of the multi-channel I/O clock generator

VERILATOR   ?= verilator
TOP         ?= ioClkGen_tb
FILELIST    ?= verilog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= Simulation finished: PASS
ERROR_LIMIT ?= 100
TIMESCALE   ?= 1ns/100ps
VFLAGS      ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG ERROR_LIMIT TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(SIM_BIN) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/cfgBusDecoder.sv */
`default_nettype none

module cfgBusDecoder import clkGenPkg::*; #(
    parameter int NumChannels = 2,
    localparam int ChanBits = chanBits(NumChannels),
    localparam int AddrWidth = ChanBits + RegSelWidth
) (
    input  wire                      cfgWrite,
    input  wire  [AddrWidth-1:0]     cfgAddr,
    input  wire  [ReadDataWidth-1:0] chanReadData [NumChannels][RegCount],
    output logic [NumChannels-1:0]   wrLower,
    output logic [NumChannels-1:0]   wrUpper,
    output logic [ReadDataWidth-1:0] cfgReadData
);

    logic [ChanBits-1:0]    chanIdx;
    logic [RegSelWidth-1:0] regCode;

    assign chanIdx = cfgAddr[AddrWidth-1:RegSelWidth];
    assign regCode = cfgAddr[RegSelWidth-1:0];

    // One strobe at most; unknown channels match no loop index
    always_comb begin
        wrLower = '0;
        wrUpper = '0;
        for (int ch = 0; ch < NumChannels; ch++) begin
            if (cfgWrite && (int'(chanIdx) == ch)) begin
                case (regCode)
                    RegLower: wrLower[ch] = 1'b1;
                    RegUpper: wrUpper[ch] = 1'b1;
                    default: begin
                        // Active and status are read only
                    end
                endcase
            end
        end
    end

    // Out of range channels read back as zero
    always_comb begin
        cfgReadData = '0;
        for (int ch = 0; ch < NumChannels; ch++) begin
            if (int'(chanIdx) == ch) begin
                cfgReadData = chanReadData[ch][regCode];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/clkCfgIf.sv */
`default_nettype none

interface clkCfgIf import clkGenPkg::*; ();

    // Shadow word and its commit pulse
    clkCfgWord_t cfg;
    logic        commit;

    // Live state of the divider
    clkCfgWord_t activeCfg;
    logic        outLevel;

    modport regs (
        output cfg,
        output commit,
        input  activeCfg,
        input  outLevel
    );

    modport divider (
        input  cfg,
        input  commit,
        output activeCfg,
        output outLevel
    );

endinterface

`default_nettype wire

/* logic/clkCfgRegs.sv */
`default_nettype none

module clkCfgRegs import clkGenPkg::*; (
    input  wire                      divided_clk_src,
    input  wire                      rst,
    input  wire                      wrLower,
    input  wire                      wrUpper,
    input  wire  [CfgDataWidth-1:0]  cfgWriteData,
    output logic [ReadDataWidth-1:0] readWords [RegCount],
    clkCfgIf.regs                    cfgBus
);

    logic [CfgDataWidth-1:0] shadowLower;
    logic [CfgDataWidth-1:0] shadowUpper;
    logic [1:0]              commitDelay;
    logic                    commitReg;
    logic                    commitPending;

    // Shadow halves
    always_ff @(posedge divided_clk_src) begin
        if (rst) begin
            shadowLower <= '0;
            shadowUpper <= '0;
        end else begin
            if (wrLower) begin
                shadowLower <= cfgWriteData;
            end
            if (wrUpper) begin
                shadowUpper <= cfgWriteData;
            end
        end
    end

    assign cfgBus.cfg.raw = {shadowUpper, shadowLower};

    // Submit delay lands the commit on the third edge after the upper write
    always_ff @(posedge divided_clk_src) begin
        if (rst) begin
            commitDelay <= '0;
            commitReg   <= 1'b0;
        end else begin
            commitDelay <= {commitDelay[0], wrUpper};
            commitReg   <= commitDelay[1];
        end
    end

    assign cfgBus.commit = commitReg;

    // Pending while either delay stage holds a write
    assign commitPending = |commitDelay;

    always_comb begin
        readWords[RegLower]     = cfgBus.cfg.raw;
        readWords[RegUpper]     = cfgBus.cfg.raw;
        readWords[RegActive]    = cfgBus.activeCfg.raw;
        readWords[RegStatus]    = '0;
        readWords[RegStatus][0] = cfgBus.outLevel;
        readWords[RegStatus][1] = commitPending;
    end

endmodule

`default_nettype wire

/* logic/clkDivider.sv */
`default_nettype none

module clkDivider import clkGenPkg::*; (
    input  wire                    divided_clk_src,
    input  wire                    rst,
    input  wire  [SourceCount-2:0] tickIn,
    output logic                   clkOut,
    clkCfgIf.divider               cfgBus
);

    clkCfgWord_t             activeCfg;
    logic [DivisorWidth-1:0] divCount;
    logic [SourceCount-1:0]  tickSources;
    logic                    tick;
    logic                    elapsed;
    logic                    outFF;

    // Active configuration
    always_ff @(posedge divided_clk_src) begin
        if (rst) begin
            activeCfg <= '0;
        end else if (cfgBus.commit) begin
            activeCfg <= cfgBus.cfg;
        end
    end

    // Source 0 ticks every cycle
    assign tickSources = {tickIn, 1'b1};
    assign tick        = tickSources[activeCfg.fields.sel];
    assign elapsed     = tick && (divCount == activeCfg.fields.divisor);

    // Division counter
    always_ff @(posedge divided_clk_src) begin
        if (rst || cfgBus.commit) begin
            divCount <= '0;
        end else if (elapsed) begin
            divCount <= '0;
        end else if (tick) begin
            divCount <= divCount + 1'b1;
        end
    end

    // One output half period per elapse
    always_ff @(posedge divided_clk_src) begin
        if (rst) begin
            outFF <= 1'b0;
        end else if (elapsed) begin
            outFF <= ~outFF;
        end
    end

    assign clkOut           = outFF;
    assign cfgBus.outLevel  = outFF;
    assign cfgBus.activeCfg = activeCfg;

endmodule

`default_nettype wire

/* logic/clkGenPkg.sv */
`default_nettype none

package clkGenPkg;

    // Bus widths
    localparam int CfgDataWidth  = 8;
    localparam int ReadDataWidth = 16;
    localparam int RegSelWidth   = 2;
    localparam int RegCount      = 1 << RegSelWidth;

    // Configuration word fields
    localparam int SelWidth     = 2;
    localparam int DivisorWidth = 14;

    // Source 0 is the clock itself and the rest come from tickIn
    localparam int SourceCount = 4;

    // Register codes in the low address bits
    localparam logic [RegSelWidth-1:0] RegLower  = 2'd0;
    localparam logic [RegSelWidth-1:0] RegUpper  = 2'd1;
    localparam logic [RegSelWidth-1:0] RegActive = 2'd2;
    localparam logic [RegSelWidth-1:0] RegStatus = 2'd3;

    typedef struct packed {
        logic [SelWidth-1:0]     sel;
        logic [DivisorWidth-1:0] divisor;
    } clkCfgFields_t;

    // Same word seen as readback data or as select/divisor
    typedef union packed {
        logic [ReadDataWidth-1:0] raw;
        clkCfgFields_t            fields;
    } clkCfgWord_t;

    // At least one channel index bit so the address never collapses
    function automatic int chanBits(input int numChannels);
        int bits;
        bits = (numChannels > 1) ? $clog2(numChannels) : 1;
        return bits;
    endfunction

endpackage

`default_nettype wire

/* logic/ioClkGen.sv */
`default_nettype none

module ioClkGen import clkGenPkg::*; #(
    parameter int NumChannels = 2,
    localparam int AddrWidth = chanBits(NumChannels) + RegSelWidth
) (
    input  wire                      divided_clk_src,
    input  wire                      rst,
    input  wire                      cfgWrite,
    input  wire  [AddrWidth-1:0]     cfgAddr,
    input  wire  [CfgDataWidth-1:0]  cfgWriteData,
    input  wire  [SourceCount-2:0]   tickIn,
    output logic [ReadDataWidth-1:0] cfgReadData,
    output logic [NumChannels-1:0]   clkOut
);

    logic [NumChannels-1:0]   wrLower;
    logic [NumChannels-1:0]   wrUpper;
    logic [ReadDataWidth-1:0] chanReadData [NumChannels][RegCount];

    cfgBusDecoder #(
        .NumChannels(NumChannels)
    ) busDecoder (
        .cfgWrite    (cfgWrite),
        .cfgAddr     (cfgAddr),
        .chanReadData(chanReadData),
        .wrLower     (wrLower),
        .wrUpper     (wrUpper),
        .cfgReadData (cfgReadData)
    );

    // One register block and divider per channel
    for (genvar ch = 0; ch < NumChannels; ch++) begin : gChannel
        clkCfgIf chanCfg ();

        clkCfgRegs cfgRegs (
            .divided_clk_src(divided_clk_src),
            .rst            (rst),
            .wrLower        (wrLower[ch]),
            .wrUpper        (wrUpper[ch]),
            .cfgWriteData   (cfgWriteData),
            .readWords      (chanReadData[ch]),
            .cfgBus         (chanCfg.regs)
        );

        clkDivider clkDiv (
            .divided_clk_src(divided_clk_src),
            .rst            (rst),
            .tickIn         (tickIn),
            .clkOut         (clkOut[ch]),
            .cfgBus         (chanCfg.divider)
        );
    end

endmodule

`default_nettype wire

/* tests/ioClkGen_asserts.sv */
`default_nettype none

module ioClkGen_asserts import clkGenPkg::*; (
    input wire                     divided_clk_src,
    input wire                     rst,
    input wire                     commit,
    input wire [ReadDataWidth-1:0] shadowCfg,
    input wire [ReadDataWidth-1:0] activeCfg,
    input wire [DivisorWidth-1:0]  divCount,
    input wire [SourceCount-2:0]   tickIn,
    input wire                     outLevel
);

    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    logic [SelWidth-1:0] activeSel;
    logic                selTick;
    logic                elapseDue;

    assign activeSel = activeCfg[ReadDataWidth-1 -: SelWidth];

    // Source n above 0 is tickIn[n-1]
    assign selTick   = (activeSel == '0) ? 1'b1 : tickIn[activeSel - 1'b1];
    assign elapseDue = selTick && (divCount == activeCfg[DivisorWidth-1:0]);

    // Commit copies the shadow word and restarts the count
    property commitLoadsActive;
        @(posedge divided_clk_src) disable iff (rst)
            commit |=> (activeCfg == $past(shadowCfg)) && (divCount == '0);
    endproperty

    // Output level moves exactly on an elapse
    property toggleOnlyOnElapse;
        @(posedge divided_clk_src) disable iff (rst)
            !$past(rst) |-> ((outLevel != $past(outLevel)) == $past(elapseDue));
    endproperty

    property countWithinDivisor;
        @(posedge divided_clk_src) disable iff (rst)
            divCount <= activeCfg[DivisorWidth-1:0];
    endproperty

    // Reset clears the divider and drops any commit in flight
    property resetClearsState;
        @(posedge divided_clk_src)
            rst |=> !outLevel && (activeCfg == '0) && (divCount == '0) && !commit;
    endproperty

    commitCheck: assert property (commitLoadsActive)
        else begin
            failCount++;
            $error("activeCfg did not take the shadow word one cycle after commit");
        end

    toggleCheck: assert property (toggleOnlyOnElapse)
        else begin
            failCount++;
            $error("clkOut changed without an elapse, or an elapse did not toggle it");
        end

    boundCheck: assert property (countWithinDivisor)
        else begin
            failCount++;
            $error("division counter ran past the active divisor");
        end

    resetCheck: assert property (resetClearsState)
        else begin
            failCount++;
            $error("divider state not cleared by reset");
        end

endmodule

bind clkDivider ioClkGen_asserts dividerChecks (
    .divided_clk_src(divided_clk_src),
    .rst            (rst),
    .commit         (cfgBus.commit),
    .shadowCfg      (cfgBus.cfg),
    .activeCfg      (activeCfg),
    .divCount       (divCount),
    .tickIn         (tickIn),
    .outLevel       (outFF)
);

`default_nettype wire

/* tests/ioClkGen_tb.sv */
`default_nettype none

module ioClkGen_tb import clkGenPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumChannels = 2;
    localparam int ChanBits    = chanBits(NumChannels);
    localparam int AddrWidth   = ChanBits + RegSelWidth;
    localparam int ClkPeriod   = 4;
    localparam int ResetCycles = 8;
    localparam int EdgeLimit   = 100;

    localparam logic [ChanBits-1:0] Chan0 = ChanBits'(0);
    localparam logic [ChanBits-1:0] Chan1 = ChanBits'(1);

    // Expected cycles per test; the watchdog allows four times the sum
    localparam int ResetTestCycles  = 2 * (2 + 5);
    localparam int CommitCycles     = 8;
    localparam int InternalCycles   = CommitCycles + 5 * 6;
    localparam int ExternalCycles   = 3 * CommitCycles + 2 * 5 * (3 + 4 + 2);
    localparam int IsolationCycles  = 4 + 3 * 6 + 8;
    localparam int BackToBackCycles = 20;
    localparam int TestCycles       = ResetCycles + ResetTestCycles + InternalCycles
                                    + ExternalCycles + IsolationCycles + BackToBackCycles;

    logic                     divided_clk_src;
    logic                     rst;
    logic                     cfgWrite;
    logic [AddrWidth-1:0]     cfgAddr;
    logic [CfgDataWidth-1:0]  cfgWriteData;
    logic [SourceCount-2:0]   tickIn;
    logic [ReadDataWidth-1:0] cfgReadData;
    logic [NumChannels-1:0]   clkOut;

    int errorCount;
    int assertFails;

    ioClkGen #(
        .NumChannels(NumChannels)
    ) UUT (
        .divided_clk_src(divided_clk_src),
        .rst            (rst),
        .cfgWrite       (cfgWrite),
        .cfgAddr        (cfgAddr),
        .cfgWriteData   (cfgWriteData),
        .tickIn         (tickIn),
        .cfgReadData    (cfgReadData),
        .clkOut         (clkOut)
    );

    always #(ClkPeriod / 2) divided_clk_src = ~divided_clk_src;

    function automatic void compareWord(input string name, input logic [15:0] expected,
                                        input logic [15:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endfunction

    function automatic void compareInt(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errorCount++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endfunction

    task automatic writeReg(input logic [ChanBits-1:0] chan, input logic [RegSelWidth-1:0] code,
                            input logic [CfgDataWidth-1:0] data);
        @(negedge divided_clk_src);
        cfgWrite     = 1'b1;
        cfgAddr      = {chan, code};
        cfgWriteData = data;
        @(negedge divided_clk_src);
        cfgWrite = 1'b0;
    endtask

    // Combinational readback is sampled inside the low clock phase
    task automatic readReg(input logic [ChanBits-1:0] chan, input logic [RegSelWidth-1:0] code,
                           output logic [ReadDataWidth-1:0] data);
        cfgAddr = {chan, code};
        #0.5;
        data = cfgReadData;
    endtask

    task automatic expectReg(input logic [ChanBits-1:0] chan, input logic [RegSelWidth-1:0] code,
                             input logic [ReadDataWidth-1:0] expected);
        logic [ReadDataWidth-1:0] data;
        readReg(chan, code, data);
        compareWord($sformatf("cfgReadData ch%0d reg%0d", chan, code), expected, data);
    endtask

    task automatic expectPending(input logic [ChanBits-1:0] chan, input logic expected);
        logic [ReadDataWidth-1:0] data;
        readReg(chan, RegStatus, data);
        compareWord($sformatf("status.pending ch%0d", chan), {15'd0, expected}, {15'd0, data[1]});
        compareWord($sformatf("status.level ch%0d", chan), {15'd0, clkOut[chan]}, {15'd0, data[0]});
        compareWord($sformatf("status.unused ch%0d", chan), 16'h0000, {data[15:2], 2'b00});
    endtask

    // Lower then upper half, tracking the commit window cycle by cycle
    task automatic commitWord(input logic [ChanBits-1:0] chan, input logic [15:0] word);
        logic [ReadDataWidth-1:0] prevActive;
        writeReg(chan, RegLower, word[7:0]);
        readReg(chan, RegActive, prevActive);
        writeReg(chan, RegUpper, word[15:8]);
        expectReg(chan, RegLower, word);
        expectPending(chan, 1'b1);
        expectReg(chan, RegActive, prevActive);
        @(negedge divided_clk_src);
        expectReg(chan, RegUpper, word);
        expectPending(chan, 1'b1);
        expectReg(chan, RegActive, prevActive);
        @(negedge divided_clk_src);
        expectPending(chan, 1'b0);
        expectReg(chan, RegActive, prevActive);
        @(negedge divided_clk_src);
        expectReg(chan, RegActive, word);
    endtask

    // Drives random strobes and counts ticks of the selected source between clkOut edges
    task automatic checkHalfPeriods(input logic [ChanBits-1:0] chan, input logic [SelWidth-1:0] sel,
                                    input int divisor, input int count);
        logic [SourceCount-1:0] sources;
        logic                   prevLevel;
        logic [31:0]            randWord;
        int                     ticks;
        int                     edges;
        int                     idle;
        bit                     synced;
        ticks     = 0;
        edges     = 0;
        idle      = 0;
        synced    = 1'b0;
        prevLevel = clkOut[chan];
        while (edges < count) begin
            @(negedge divided_clk_src);
            idle++;
            if (clkOut[chan] != prevLevel) begin
                if (synced) begin
                    edges++;
                    compareInt($sformatf("clkOut[%0d] half period", chan), divisor + 1, ticks);
                end
                synced = 1'b1;
                ticks  = 0;
                idle   = 0;
            end else if (idle > EdgeLimit) begin
                errorCount++;
                $display("No clkOut edge on channel %0d within %0d cycles", chan, EdgeLimit);
                break;
            end
            prevLevel = clkOut[chan];
            randWord  = $urandom;
            tickIn    = randWord[SourceCount-2:0];
            sources   = {tickIn, 1'b1};
            if (sources[sel]) begin
                ticks++;
            end
        end
    endtask

    initial begin
        logic [ChanBits-1:0] chan;
        void'($urandom(32'h19f66f27));
        errorCount      = 0;
        assertFails     = 0;
        divided_clk_src = 1'b0;
        rst             = 1'b1;
        cfgWrite        = 1'b0;
        cfgAddr         = '0;
        cfgWriteData    = '0;
        tickIn          = '0;
        repeat (ResetCycles) @(posedge divided_clk_src);
        @(negedge divided_clk_src);
        rst = 1'b0;

        for (int ch = 0; ch < NumChannels; ch++) begin
            chan = ChanBits'(ch);
            @(negedge divided_clk_src);
            expectReg(chan, RegLower, 16'h0000);
            expectReg(chan, RegUpper, 16'h0000);
            expectReg(chan, RegActive, 16'h0000);
            @(negedge divided_clk_src);
            expectPending(chan, 1'b0);
            checkHalfPeriods(chan, 2'd0, 0, 4);
        end

        // Internal source with divisor 5
        commitWord(Chan0, 16'h0005);
        checkHalfPeriods(Chan0, 2'd0, 5, 4);

        // External strobes on tickIn[0..2]
        commitWord(Chan1, 16'h4002);
        checkHalfPeriods(Chan1, 2'd1, 2, 4);
        commitWord(Chan1, 16'h8003);
        checkHalfPeriods(Chan1, 2'd2, 3, 4);
        commitWord(Chan1, 16'hC001);
        checkHalfPeriods(Chan1, 2'd3, 1, 4);

        // Channel 0 untouched by channel 1 traffic
        @(negedge divided_clk_src);
        expectReg(Chan0, RegLower, 16'h0005);
        expectReg(Chan0, RegActive, 16'h0005);
        checkHalfPeriods(Chan0, 2'd0, 5, 2);

        // Writes to read-only codes; a 1-bit channel index has no out of range address
        writeReg(Chan0, RegActive, 8'hAA);
        writeReg(Chan0, RegStatus, 8'h55);
        repeat (3) @(negedge divided_clk_src);
        expectReg(Chan0, RegLower, 16'h0005);
        expectReg(Chan0, RegActive, 16'h0005);
        expectReg(Chan1, RegLower, 16'hC001);
        @(negedge divided_clk_src);
        expectPending(Chan0, 1'b0);

        // Two upper writes on consecutive edges and a lower write between their commits
        writeReg(Chan0, RegLower, 8'h11);
        @(negedge divided_clk_src);
        cfgWrite     = 1'b1;
        cfgAddr      = {Chan0, RegUpper};
        cfgWriteData = 8'h02;
        @(negedge divided_clk_src);
        cfgWriteData = 8'h03;
        @(negedge divided_clk_src);
        cfgWrite = 1'b0;
        expectPending(Chan0, 1'b1);
        // First commit lands with the lower write and keeps the older shadow word
        writeReg(Chan0, RegLower, 8'h22);
        expectReg(Chan0, RegActive, 16'h0311);
        @(negedge divided_clk_src);
        expectReg(Chan0, RegActive, 16'h0322);

        // Reset inside the commit window and a shadow write before the commit would land
        writeReg(Chan0, RegUpper, 8'h04);
        rst = 1'b1;
        @(negedge divided_clk_src);
        rst          = 1'b0;
        cfgWrite     = 1'b1;
        cfgAddr      = {Chan0, RegLower};
        cfgWriteData = 8'h33;
        @(negedge divided_clk_src);
        cfgWrite = 1'b0;
        repeat (3) @(negedge divided_clk_src);
        expectReg(Chan0, RegActive, 16'h0000);
        expectReg(Chan0, RegLower, 16'h0033);
        @(negedge divided_clk_src);
        expectPending(Chan0, 1'b0);

        @(negedge divided_clk_src);
        assertFails = UUT.gChannel[0].clkDiv.dividerChecks.failCount
                    + UUT.gChannel[1].clkDiv.dividerChecks.failCount;
        $display("Errors: %0d readback or period, %0d assertion", errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(4 * TestCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the tests did not complete", 4 * TestCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/clkGenPkg.sv
logic/clkCfgIf.sv
logic/cfgBusDecoder.sv
logic/clkCfgRegs.sv
logic/clkDivider.sv
logic/ioClkGen.sv
tests/ioClkGen_asserts.sv
tests/ioClkGen_tb.sv
